/* chip8_core.f */
+incdir+src
src/chip8_isa_pkg.sv
src/chip8_bus_pkg.sv
src/chip8_decoder.sv
src/chip8_alu.sv
src/chip8_regfile.sv
src/chip8_sequencer.sv
src/chip8_core.sv
tb/chip8_chk.sv
tb/chip8_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the CHIP-8 core testbench with Verilator, run it, judge the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -j 0 --top-module chip8_tb \
  --Mdir "$build_dir" -f chip8_core.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/Vchip8_tb" +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$log"; then
  exit 0
fi
exit 1

/* tb/chip8_tb.sv */
`timescale 1ns/100ps
`include "chip8_consts.svh"

module chip8_tb;
  import chip8_bus_pkg::*;

  localparam logic [31:0] ALU_NS = 32'hE765_4321; // 8xyN low nibbles

  logic                     clk_in = 1'b0;
  logic                     rst = 1'b1;
  logic [7:0]               rd_data = 8'h00;
  logic                     wr_ready = 1'b0;
  logic [`CHIP8_ADDR_W-1:0] rd_addr;
  mem_wr_t                  wr_req;
  logic                     wr_valid;
  logic                     halted;

  logic [7:0]               mem [4096];
  logic [7:0]               vm [16]; // expected V0..VF
  logic [`CHIP8_ADDR_W-1:0] im;
  logic [`CHIP8_ADDR_W-1:0] pc;      // next free program slot
  mem_wr_t                  exp_q [$];
  logic [15:0]              build_lfsr = 16'd15;
  logic [15:0]              ready_lfsr = 16'd15;
  int                       n_instr = 0;
  int                       n_bytes = 0;

  chip8_core uut (
    .clk_in     (clk_in),
    .rst_i      (rst),
    .rd_data_i  (rd_data),
    .wr_ready_i (wr_ready),
    .rd_addr_o  (rd_addr),
    .wr_req_o   (wr_req),
    .wr_valid_o (wr_valid),
    .halted_o   (halted)
  );

  always #5 clk_in = ~clk_in;

  function automatic logic [15:0] galois_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "run aborted");
  endtask

  task automatic rand_byte(output logic [7:0] b);
    for (int k = 0; k < 8; k++) begin
      build_lfsr = galois_step(build_lfsr);
      b[k] = build_lfsr[0];
    end
  endtask

  task automatic put_op(input logic [11:0] addr, input logic [15:0] op);
    mem[addr]        = op[15:8];
    mem[addr + 1'b1] = op[7:0];
    n_instr++;
  endtask

  task automatic emit(input logic [15:0] op);
    put_op(pc, op);
    pc = pc + 12'd2;
  endtask

  task automatic ld_byte(input logic [3:0] x, input logic [7:0] kk);
    emit({4'h6, x, kk});
    vm[x] = kk;
  endtask

  task automatic ld_reg(input logic [3:0] x, input logic [3:0] y);
    emit({4'h8, x, y, 4'h0});
    vm[x] = vm[y];
  endtask

  task automatic add_byte(input logic [3:0] x, input logic [7:0] kk);
    emit({4'h7, x, kk});
    vm[x] = vm[x] + kk; // VF untouched
  endtask

  // r[8] is the flag, written after the result
  task automatic alu_xy(input logic [3:0] x, input logic [3:0] y, input logic [3:0] n);
    logic [7:0] a;
    logic [7:0] b;
    logic [8:0] r;
    a = vm[x];
    b = vm[y];
    case (n)
      4'h1: r = {1'b0, a | b};
      4'h2: r = {1'b0, a & b};
      4'h3: r = {1'b0, a ^ b};
      4'h4: r = {1'b0, a} + {1'b0, b};
      4'h5: r = {a >= b, 8'(a - b)};
      4'h6: r = {a[0], 1'b0, a[7:1]};
      4'h7: r = {b >= a, 8'(b - a)};
      default: r = {a[7], a[6:0], 1'b0};
    endcase
    emit({4'h8, x, y, n});
    vm[x]  = r[7:0];
    vm[15] = {7'd0, r[8]};
  endtask

  task automatic ld_i(input logic [11:0] nnn);
    emit({4'hA, nnn});
    im = nnn;
  endtask

  task automatic add_i(input logic [3:0] x);
    emit({4'hF, x, 8'h1E});
    im = im + {4'd0, vm[x]};
  endtask

  task automatic store_blk(input logic [3:0] x);
    mem_wr_t w;
    emit({4'hF, x, 8'h55});
    for (int k = 0; k <= int'(x); k++) begin
      w.addr = im + 12'(k);
      w.data = vm[k];
      exp_q.push_back(w);
      n_bytes++;
    end
  endtask

  task automatic load_blk(input logic [3:0] x);
    emit({4'hF, x, 8'h65});
    for (int k = 0; k <= int'(x); k++) begin
      vm[k] = mem[im + 12'(k)];
    end
  endtask

  // skip followed by a marker that adds one bit into VB
  task automatic skip_case(input logic [15:0] op, input logic [7:0] marker);
    logic taken;
    case (op[15:12])
      4'h3: taken = (vm[op[11:8]] == op[7:0]);
      4'h4: taken = (vm[op[11:8]] != op[7:0]);
      4'h5: taken = (vm[op[11:8]] == vm[op[7:4]]);
      default: taken = (vm[op[11:8]] != vm[op[7:4]]);
    endcase
    emit(op);
    if (taken) emit({8'h7B, marker});
    else add_byte(4'hB, marker);
  endtask

  task automatic build_program();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    for (int k = 0; k < 4096; k++) begin
      mem[k] = 8'(k) ^ 8'(k >> 4);
    end
    for (int k = 0; k < 16; k++) begin
      rand_byte(a);
      mem[12'h400 + 12'(k)] = a; // source block for Fx65
      vm[k] = 8'h00;
    end
    pc = `CHIP8_PC_RESET;
    im = '0;
    rand_byte(a);
    rand_byte(b);
    rand_byte(c);
    ld_byte(4'h0, a);
    ld_byte(4'h1, b);
    ld_reg(4'h2, 4'h1);
    add_byte(4'h2, c);
    for (int k = 0; k < 8; k++) begin
      ld_reg(4'h3, 4'h0);
      alu_xy(4'h3, 4'h2, ALU_NS[4*k +: 4]);
      ld_i(12'h300 + 12'(16 * k));
      store_blk(4'hF);
    end
    alu_xy(4'hF, 4'h1, 4'h4); // flag must win over the sum
    ld_byte(4'hB, 8'h00);
    ld_byte(4'hC, 8'h00);
    ld_reg(4'h4, 4'h0);
    ld_reg(4'h5, 4'h0);
    add_byte(4'h5, 8'h01);
    skip_case({8'h30, vm[0]}, 8'h01);
    skip_case({8'h30, ~vm[0]}, 8'h02);
    skip_case({8'h40, vm[0]}, 8'h04);
    skip_case({8'h40, ~vm[0]}, 8'h08);
    skip_case(16'h5040, 8'h10);
    skip_case(16'h5050, 8'h20);
    skip_case(16'h9040, 8'h40);
    skip_case(16'h9050, 8'h80);
    emit({4'h1, pc + 12'd4}); // jump over the marker
    emit(16'h7C01);
    put_op(12'h600, 16'h7C02);
    put_op(12'h602, 16'h00EE);
    put_op(12'h604, 16'h7C04); // past the return
    emit(16'h2600);
    vm[12] = vm[12] + 8'h02;
    add_byte(4'hC, 8'h08);
    ld_i(12'h380);
    store_blk(4'hF);
    ld_byte(4'hD, 8'h10);
    ld_i(12'h3F0);
    add_i(4'hD);
    load_blk(4'h9);
    ld_i(12'h4F0);
    add_i(4'hD);
    store_blk(4'h9);
    emit(16'h0123); // illegal, core halts here
    emit(16'hFF55);
  endtask

  always @(posedge clk_in) begin
    ready_lfsr = galois_step(ready_lfsr);
    wr_ready <= ready_lfsr[0];
  end

  // one-cycle read, writes checked against the expected queue
  always @(posedge clk_in) begin
    mem_wr_t head;
    rd_data <= mem[rd_addr];
    if (!rst && wr_valid && wr_ready) begin
      assert (exp_q.size() != 0)
        else report_failure($sformatf("unexpected write of %02h to %03h at %0t",
                                      wr_req.data, wr_req.addr, $time));
      head = exp_q.pop_front();
      assert (wr_req == head)
        else report_failure($sformatf("MISMATCH at %0t: wrote %02h to %03h, expected %02h to %03h",
                                      $time, wr_req.data, wr_req.addr, head.data, head.addr));
      mem[wr_req.addr] = wr_req.data;
    end
  end

  always @(negedge clk_in) begin
    assert (uut.u_chk.fail_cnt == 0)
      else report_failure("a protocol assertion on the core ports failed");
  end

  initial begin
    int limit;
    #1;
    limit = 40 * n_instr + 8 * n_bytes;
    repeat (limit) @(posedge clk_in);
    report_failure($sformatf("timeout, core still running after %0d cycles", limit));
  end

  initial begin
    build_program();
    repeat (5) @(posedge clk_in);
    rst <= 1'b0;
    @(posedge clk_in);
    while (!halted) @(negedge clk_in);
    repeat (8) @(negedge clk_in); // room for a stray write
    assert (exp_q.size() == 0)
      else report_failure($sformatf("core halted with %0d stores missing", exp_q.size()));
    if (uut.u_chk.fail_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      report_failure("a protocol assertion on the core ports failed");
    end
  end

endmodule

/* tb/chip8_chk.sv */
`timescale 1ns/100ps
`include "chip8_consts.svh"

module chip8_chk (
  input logic                     clk_in,
  input logic                     rst_i,
  input logic [`CHIP8_ADDR_W-1:0] rd_addr_i,
  input chip8_bus_pkg::mem_wr_t   wr_req_i,
  input logic                     wr_valid_i,
  input logic                     wr_ready_i,
  input logic                     halted_i
);

  int unsigned fail_cnt = 0; // polled by chip8_tb

  // first sampled cycle out of reset
  reset_state_a: assert property (@(posedge clk_in) $fell(rst_i) |->
      (rd_addr_i == `CHIP8_PC_RESET) && !wr_valid_i && !halted_i)
    else begin
      $error("fetch address, write valid or halt wrong after reset");
      fail_cnt++;
    end

  write_hold_a: assert property (@(posedge clk_in) disable iff (rst_i)
      wr_valid_i && !wr_ready_i |=> wr_valid_i && $stable(wr_req_i))
    else begin
      $error("write request dropped or changed while waiting for ready");
      fail_cnt++;
    end

  // read port frozen under back-pressure
  no_fetch_in_wait_a: assert property (@(posedge clk_in) disable iff (rst_i)
      wr_valid_i && !wr_ready_i |=> $stable(rd_addr_i))
    else begin
      $error("read address moved during a write wait");
      fail_cnt++;
    end

  write_release_a: assert property (@(posedge clk_in) disable iff (rst_i)
      wr_valid_i && wr_ready_i |=> !wr_valid_i || !$stable(wr_req_i))
    else begin
      $error("accepted write request repeated");
      fail_cnt++;
    end

  halt_sticky_a: assert property (@(posedge clk_in) disable iff (rst_i)
      halted_i |=> halted_i)
    else begin
      $error("halt flag cleared without reset");
      fail_cnt++;
    end

  halt_quiet_a: assert property (@(posedge clk_in) disable iff (rst_i)
      halted_i |-> !wr_valid_i)
    else begin
      $error("write request while halted");
      fail_cnt++;
    end

endmodule

bind chip8_core chip8_chk u_chk (
  .clk_in     (clk_in),
  .rst_i      (rst_i),
  .rd_addr_i  (rd_addr_o),
  .wr_req_i   (wr_req_o),
  .wr_valid_i (wr_valid_o),
  .wr_ready_i (wr_ready_i),
  .halted_i   (halted_o)
);

/* src/chip8_core.sv */
`timescale 1ns/100ps
`include "chip8_consts.svh"

module chip8_core (
  input  logic                     clk_in,
  input  logic                     rst_i,
  input  logic [7:0]               rd_data_i,
  input  logic                     wr_ready_i,
  output logic [`CHIP8_ADDR_W-1:0] rd_addr_o,
  output chip8_bus_pkg::mem_wr_t   wr_req_o,
  output logic                     wr_valid_o,
  output logic                     halted_o
);
  import chip8_isa_pkg::*;

  logic [15:0]              opcode;
  decoded_t                 dec;
  logic [7:0]               vx;
  logic [7:0]               vy;
  logic [7:0]               alu_b;
  logic [7:0]               alu_result;
  logic                     alu_flag;
  logic                     alu_cond;
  logic [`CHIP8_ADDR_W-1:0] i_reg;
  logic                     rf_we;
  logic [3:0]               rf_wsel;
  logic [7:0]               rf_wdata;
  logic                     vf_we;
  logic                     vf;
  logic                     i_we;
  logic [`CHIP8_ADDR_W-1:0] i_data;

  assign alu_b = dec.use_imm ? dec.imm8 : vy; // kk forms compare/add the byte

  chip8_sequencer u_seq (
    .clk_in       (clk_in),
    .rst_i        (rst_i),
    .rd_data_i    (rd_data_i),
    .dec_i        (dec),
    .vx_i         (vx),
    .vy_i         (vy),
    .i_i          (i_reg),
    .alu_result_i (alu_result),
    .alu_flag_i   (alu_flag),
    .alu_cond_i   (alu_cond),
    .wr_ready_i   (wr_ready_i),
    .opcode_o     (opcode),
    .rd_addr_o    (rd_addr_o),
    .wr_req_o     (wr_req_o),
    .wr_valid_o   (wr_valid_o),
    .halted_o     (halted_o),
    .rf_we_o      (rf_we),
    .rf_wsel_o    (rf_wsel),
    .rf_wdata_o   (rf_wdata),
    .vf_we_o      (vf_we),
    .vf_o         (vf),
    .i_we_o       (i_we),
    .i_data_o     (i_data)
  );

  chip8_decoder u_dec (
    .opcode_i (opcode),
    .dec_o    (dec)
  );

  chip8_alu u_alu (
    .op_i     (dec.alu_op),
    .a_i      (vx),
    .b_i      (alu_b),
    .result_o (alu_result),
    .flag_o   (alu_flag),
    .cond_o   (alu_cond)
  );

  chip8_regfile u_rf (
    .clk_in   (clk_in),
    .rst_i    (rst_i),
    .rx_sel_i (dec.vx),
    .ry_sel_i (dec.vy),
    .we_i     (rf_we),
    .wsel_i   (rf_wsel),
    .wdata_i  (rf_wdata),
    .vf_we_i  (vf_we),
    .vf_i     (vf),
    .i_we_i   (i_we),
    .i_data_i (i_data),
    .vx_o     (vx),
    .vy_o     (vy),
    .i_o      (i_reg)
  );

endmodule

/* src/chip8_sequencer.sv */
`timescale 1ns/100ps
`include "chip8_consts.svh"

module chip8_sequencer (
  input  logic                     clk_in,
  input  logic                     rst_i,
  input  logic [7:0]               rd_data_i,
  input  chip8_isa_pkg::decoded_t  dec_i,
  input  logic [7:0]               vx_i,
  input  logic [7:0]               vy_i,
  input  logic [`CHIP8_ADDR_W-1:0] i_i,
  input  logic [7:0]               alu_result_i,
  input  logic                     alu_flag_i,
  input  logic                     alu_cond_i,
  input  logic                     wr_ready_i,
  output logic [15:0]              opcode_o,
  output logic [`CHIP8_ADDR_W-1:0] rd_addr_o,
  output chip8_bus_pkg::mem_wr_t   wr_req_o,
  output logic                     wr_valid_o,
  output logic                     halted_o,
  output logic                     rf_we_o,
  output logic [3:0]               rf_wsel_o,
  output logic [7:0]               rf_wdata_o,
  output logic                     vf_we_o,
  output logic                     vf_o,
  output logic                     i_we_o,
  output logic [`CHIP8_ADDR_W-1:0] i_data_o
);
  import chip8_isa_pkg::*;

  localparam int SP_W = $clog2(`CHIP8_STACK_DEPTH);

  typedef enum logic [2:0] {
    FETCH_HI,
    FETCH_LO,
    CAPTURE,
    EXEC,
    BLK_RD,
    BLK_WR,
    HALT
  } state_e;

  state_e                   state_q;
  logic [`CHIP8_ADDR_W-1:0] pc_q;
  logic [`CHIP8_ADDR_W-1:0] pc_next;
  logic [`CHIP8_ADDR_W-1:0] stack_q [`CHIP8_STACK_DEPTH];
  logic [SP_W-1:0]          sp_q;
  logic [15:0]              opcode_q;
  logic [3:0]               blk_cnt;
  logic                     rd_phase; // high when the block read data is on rd_data_i
  logic                     in_exec;
  logic                     in_blk;
  logic                     blk_done;

  assign in_exec  = (state_q == EXEC);
  assign in_blk   = (state_q == BLK_RD) || (state_q == BLK_WR);
  assign blk_done = (blk_cnt == opcode_q[11:8]);
  assign halted_o = (state_q == HALT);

  // during a block transfer the x field walks V0..Vx
  assign opcode_o = in_blk ? {opcode_q[15:12], blk_cnt, opcode_q[7:0]} : opcode_q;

  always_comb begin
    pc_next = pc_q + 2'd2;
    case (dec_i.cls)
      JP, CALL: pc_next = dec_i.addr12;
      RET:      pc_next = stack_q[sp_q - 1'b1] + 2'd2;
      SKIP: begin
        if (alu_cond_i) pc_next = pc_q + 3'd4;
      end
      default: ;
    endcase
  end

  always_comb begin
    rf_we_o    = 1'b0;
    rf_wdata_o = alu_result_i;
    if (state_q == BLK_RD) begin
      rf_we_o    = rd_phase;
      rf_wdata_o = rd_data_i;
    end else if (in_exec && dec_i.cls == LD) begin
      rf_we_o    = 1'b1;
      rf_wdata_o = dec_i.use_imm ? dec_i.imm8 : vy_i;
    end else if (in_exec && dec_i.cls == ALU) begin
      rf_we_o = 1'b1;
    end
  end

  assign rf_wsel_o = dec_i.vx;
  assign vf_we_o   = in_exec && dec_i.cls == ALU && dec_i.sets_vf;
  assign vf_o      = alu_flag_i;
  assign i_we_o    = in_exec && (dec_i.cls == LD_I || dec_i.cls == ADD_I);
  assign i_data_o  = (dec_i.cls == LD_I) ? dec_i.addr12
                                         : i_i + {{(`CHIP8_ADDR_W-8){1'b0}}, vx_i};

  always_ff @(posedge clk_in) begin
    if (in_exec && dec_i.cls == CALL) begin
      stack_q[sp_q] <= pc_q; // return lands on pc + 2
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_i) begin
      state_q    <= FETCH_HI;
      pc_q       <= `CHIP8_PC_RESET;
      rd_addr_o  <= `CHIP8_PC_RESET;
      sp_q       <= '0;
      blk_cnt    <= '0;
      rd_phase   <= 1'b0;
      wr_valid_o <= 1'b0;
    end else begin
      case (state_q)
        FETCH_HI: begin
          rd_addr_o <= pc_q + 1'b1;
          state_q   <= FETCH_LO;
        end
        FETCH_LO: begin
          opcode_q[15:8] <= rd_data_i;
          state_q        <= CAPTURE;
        end
        CAPTURE: begin
          opcode_q[7:0] <= rd_data_i;
          state_q       <= EXEC;
        end
        EXEC: begin
          blk_cnt  <= '0;
          rd_phase <= 1'b0;
          case (dec_i.cls)
            STORE_BLK: state_q <= BLK_WR;
            LOAD_BLK: begin
              rd_addr_o <= i_i;
              state_q   <= BLK_RD;
            end
            ILLEGAL: state_q <= HALT;
            default: begin
              pc_q      <= pc_next;
              rd_addr_o <= pc_next;
              state_q   <= FETCH_HI;
            end
          endcase
          if (dec_i.cls == CALL) sp_q <= sp_q + 1'b1;
          else if (dec_i.cls == RET) sp_q <= sp_q - 1'b1;
        end
        BLK_RD: begin
          rd_phase <= ~rd_phase;
          if (rd_phase) begin
            if (blk_done) begin
              pc_q      <= pc_next;
              rd_addr_o <= pc_next;
              state_q   <= FETCH_HI;
            end else begin
              blk_cnt   <= blk_cnt + 1'b1;
              rd_addr_o <= i_i + {{(`CHIP8_ADDR_W-4){1'b0}}, blk_cnt + 4'd1};
            end
          end
        end
        BLK_WR: begin
          if (!wr_valid_o) begin
            wr_req_o.addr <= i_i + {{(`CHIP8_ADDR_W-4){1'b0}}, blk_cnt};
            wr_req_o.data <= vx_i;
            wr_valid_o    <= 1'b1;
          end else if (wr_ready_i) begin // transfer done
            wr_valid_o <= 1'b0;
            blk_cnt    <= blk_cnt + 1'b1;
            if (blk_done) begin
              pc_q      <= pc_next;
              rd_addr_o <= pc_next;
              state_q   <= FETCH_HI;
            end
          end
        end
        default: ; // HALT holds until reset
      endcase
    end
  end

endmodule

/* src/chip8_regfile.sv */
`timescale 1ns/100ps
`include "chip8_consts.svh"

module chip8_regfile (
  input  logic                     clk_in,
  input  logic                     rst_i,
  input  logic [3:0]               rx_sel_i,
  input  logic [3:0]               ry_sel_i,
  input  logic                     we_i,
  input  logic [3:0]               wsel_i,
  input  logic [7:0]               wdata_i,
  input  logic                     vf_we_i,
  input  logic                     vf_i,
  input  logic                     i_we_i,
  input  logic [`CHIP8_ADDR_W-1:0] i_data_i,
  output logic [7:0]               vx_o,
  output logic [7:0]               vy_o,
  output logic [`CHIP8_ADDR_W-1:0] i_o
);

  logic [7:0]               v_q [`CHIP8_NUM_REGS];
  logic [`CHIP8_ADDR_W-1:0] i_q;

  always_ff @(posedge clk_in) begin
    if (rst_i) begin
      for (int k = 0; k < `CHIP8_NUM_REGS; k++) begin
        v_q[k] <= 8'h00;
      end
      i_q <= '0;
    end else begin
      if (we_i) v_q[wsel_i] <= wdata_i;
      // flag strobe last, so 8FyN ends up holding the flag
      if (vf_we_i) v_q[`CHIP8_NUM_REGS-1] <= {7'd0, vf_i};
      if (i_we_i) i_q <= i_data_i;
    end
  end

  assign vx_o = v_q[rx_sel_i];
  assign vy_o = v_q[ry_sel_i];
  assign i_o  = i_q;

endmodule

/* src/chip8_alu.sv */
`timescale 1ns/100ps

module chip8_alu (
  input  chip8_isa_pkg::alu_op_e op_i,
  input  logic [7:0]             a_i,
  input  logic [7:0]             b_i,
  output logic [7:0]             result_o,
  output logic                   flag_o,
  output logic                   cond_o
);
  import chip8_isa_pkg::*;

  logic [8:0] sum;

  assign sum = {1'b0, a_i} + {1'b0, b_i};

  always_comb begin
    result_o = b_i; // pass by default
    flag_o   = 1'b0;
    cond_o   = 1'b0;
    case (op_i)
      ALU_OR:  result_o = a_i | b_i;
      ALU_AND: result_o = a_i & b_i;
      ALU_XOR: result_o = a_i ^ b_i;
      ALU_ADD: begin
        result_o = sum[7:0];
        flag_o   = sum[8];
      end
      ALU_SUB: begin
        result_o = a_i - b_i;
        flag_o   = (a_i >= b_i); // no borrow
      end
      ALU_SUBN: begin
        result_o = b_i - a_i;
        flag_o   = (b_i >= a_i);
      end
      ALU_SHR: begin
        result_o = {1'b0, a_i[7:1]};
        flag_o   = a_i[0];
      end
      ALU_SHL: begin
        result_o = {a_i[6:0], 1'b0};
        flag_o   = a_i[7];
      end
      ALU_EQ: cond_o = (a_i == b_i);
      ALU_NE: cond_o = (a_i != b_i);
      default: ;
    endcase
  end

endmodule

/* src/chip8_decoder.sv */
`timescale 1ns/100ps

module chip8_decoder (
  input  logic [15:0]             opcode_i,
  output chip8_isa_pkg::decoded_t dec_o
);
  import chip8_isa_pkg::*;

  always_comb begin
    dec_o.cls     = ILLEGAL;
    dec_o.alu_op  = ALU_PASS;
    dec_o.vx      = opcode_i[11:8];
    dec_o.vy      = opcode_i[7:4];
    dec_o.imm8    = opcode_i[7:0];
    dec_o.addr12  = opcode_i[11:0];
    dec_o.use_imm = 1'b0;
    dec_o.sets_vf = 1'b0;

    casez (opcode_i)
      16'h00EE: dec_o.cls = RET; // other 0nnn stay illegal
      16'h1???: dec_o.cls = JP;
      16'h2???: dec_o.cls = CALL;
      16'h3???: begin
        dec_o.cls     = SKIP;
        dec_o.alu_op  = ALU_EQ;
        dec_o.use_imm = 1'b1;
      end
      16'h4???: begin
        dec_o.cls     = SKIP;
        dec_o.alu_op  = ALU_NE;
        dec_o.use_imm = 1'b1;
      end
      16'h5??0: begin
        dec_o.cls    = SKIP;
        dec_o.alu_op = ALU_EQ;
      end
      16'h6???: begin
        dec_o.cls     = LD;
        dec_o.use_imm = 1'b1;
      end
      16'h7???: begin
        dec_o.cls     = ALU;
        dec_o.alu_op  = ALU_ADD;
        dec_o.use_imm = 1'b1; // no carry into VF here
      end
      16'h8???: begin
        dec_o.cls     = ALU;
        dec_o.sets_vf = 1'b1;
        case (opcode_i[3:0])
          4'h0: begin
            dec_o.cls     = LD;
            dec_o.sets_vf = 1'b0;
          end
          4'h1: dec_o.alu_op = ALU_OR;
          4'h2: dec_o.alu_op = ALU_AND;
          4'h3: dec_o.alu_op = ALU_XOR;
          4'h4: dec_o.alu_op = ALU_ADD;
          4'h5: dec_o.alu_op = ALU_SUB;
          4'h6: dec_o.alu_op = ALU_SHR;
          4'h7: dec_o.alu_op = ALU_SUBN;
          4'hE: dec_o.alu_op = ALU_SHL;
          default: begin
            dec_o.cls     = ILLEGAL;
            dec_o.sets_vf = 1'b0;
          end
        endcase
      end
      16'h9??0: begin
        dec_o.cls    = SKIP;
        dec_o.alu_op = ALU_NE;
      end
      16'hA???: dec_o.cls = LD_I;
      16'hF?1E: dec_o.cls = ADD_I;
      16'hF?55: dec_o.cls = STORE_BLK;
      16'hF?65: dec_o.cls = LOAD_BLK;
      default: ;
    endcase
  end

endmodule

/* src/chip8_bus_pkg.sv */
`include "chip8_consts.svh"

package chip8_bus_pkg;

  // one byte write toward memory, qualified by wr_valid/wr_ready
  typedef struct packed {
    logic [`CHIP8_ADDR_W-1:0] addr;
    logic [7:0]               data;
  } mem_wr_t;

endpackage

/* src/chip8_isa_pkg.sv */
`include "chip8_consts.svh"

package chip8_isa_pkg;

  typedef enum logic [3:0] {
    JP,
    CALL,
    RET,
    SKIP,      // 3xkk 4xkk 5xy0 9xy0
    LD,        // 6xkk and 8xy0
    ALU,       // 7xkk and 8xyN
    LD_I,
    ADD_I,
    STORE_BLK, // Fx55
    LOAD_BLK,  // Fx65
    ILLEGAL
  } instr_class_e;

  typedef enum logic [3:0] {
    ALU_OR,
    ALU_AND,
    ALU_XOR,
    ALU_ADD,
    ALU_SUB,
    ALU_SUBN,
    ALU_SHR,
    ALU_SHL,
    ALU_PASS,
    ALU_EQ,
    ALU_NE
  } alu_op_e;

  typedef struct packed {
    instr_class_e             cls;
    alu_op_e                  alu_op;
    logic [3:0]               vx;
    logic [3:0]               vy;
    logic [7:0]               imm8;
    logic [`CHIP8_ADDR_W-1:0] addr12;
    logic                     use_imm; // operand b is imm8, not VY
    logic                     sets_vf;
  } decoded_t;

endpackage

/* src/chip8_consts.svh */
`ifndef CHIP8_CONSTS_SVH
`define CHIP8_CONSTS_SVH

// first opcode fetch after reset
`define CHIP8_PC_RESET 12'h200

// byte address into the 4 KB memory
`define CHIP8_ADDR_W 12

// V0..VF, VF doubles as the flag register
`define CHIP8_NUM_REGS 16

`define CHIP8_STACK_DEPTH 16 // nesting limit for CALL

`endif
